// ==== pe_type_c.f ====
hdl/pe_pkg.sv
hdl/register_pipe.sv
hdl/fxp_add.sv
hdl/fxp_mul.sv
hdl/fxp_acc.sv
hdl/pe_type_c.sv
bench/tb_clkgen.sv
bench/tb_pe_type_c.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pe_type_c testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f pe_type_c.f --top-module tb_pe_type_c \
    -Mdir obj_dir -o sim_pe_type_c
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_pe_type_c > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $LOG"
exit 1

// ==== bench/tb_pe_type_c.sv ====
module tb_pe_type_c;

    localparam int W       = pe_pkg::DWIDTH;
    localparam int TIMEOUT = 200;                                   // cycles per wait
    localparam int GAP     = pe_pkg::PE_LAT + pe_pkg::MUL_LAT + 2;  // idle before opcode change
    localparam pe_pkg::pe_op_e ADD  = pe_pkg::OP_ADD;
    localparam pe_pkg::pe_op_e ACC  = pe_pkg::OP_ACC;
    localparam pe_pkg::pe_op_e MUL  = pe_pkg::OP_MUL;
    localparam pe_pkg::pe_op_e MACC = pe_pkg::OP_MACC;
    localparam pe_pkg::pe_op_e NOP  = pe_pkg::OP_NOP;

    typedef struct packed {
        pe_pkg::pe_op_e op;
        logic           clr;
        logic           av;
        logic           bv;
        logic           ra;                     // a drawn from the lfsr
        logic           rb;                     // b drawn from the lfsr
        logic [W-1:0]   a;
        logic [W-1:0]   b;
        logic           he;                     // hand computed o_out1 given
        logic [W-1:0]   res;
    } row_t;

    logic           clk, arst_n;
    pe_pkg::pe_op_e op;
    logic [W-1:0]   a, b, out1, out2;
    logic           a_vld, b_vld, acc_clr, out1_vld, out2_vld;

    row_t           tbl[$];
    logic [31:0]    lfsr;
    logic [W-1:0]   acc_model;                  // running sum of the reference
    logic           exp_v1[$], exp_v2[$];       // one entry per driven cycle
    logic [W-1:0]   exp_d1[$], exp_d2[$];
    int             n_chk, n_err1, n_err2, n_err_misc;

    tb_clkgen u_clkgen (.o_clk(clk), .o_arst_n(arst_n));

    pe_type_c UUT (
        .clk(clk), .i_arst_n(arst_n), .i_op(op),
        .i_a(a), .i_a_valid(a_vld), .i_b(b), .i_b_valid(b_vld), .i_acc_clr(acc_clr),
        .o_out1(out1), .o_out1_valid(out1_vld), .o_out2(out2), .o_out2_valid(out2_vld)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic draw(output logic [W-1:0] v);
        for (int i = 0; i < W; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];                     // one step per bit
        end
    endtask

    // signed Q16.16 product, floor to the grid, wraps to 32 bits
    function automatic logic [W-1:0] q_mul(input logic [W-1:0] x, input logic [W-1:0] y);
        longint sx, sy, p;
        sx = $signed(x);
        sy = $signed(y);
        p  = sx * sy;
        return W'(p >>> pe_pkg::FRAC);
    endfunction

    function automatic logic pending();
        logic p;
        p = 1'b0;
        foreach (exp_v1[i]) begin
            p = p | exp_v1[i] | exp_v2[i];
        end
        return p;
    endfunction

    task automatic put(input pe_pkg::pe_op_e o, input logic [2:0] f, input logic [1:0] rnd,
                       input logic [W-1:0] va, input logic [W-1:0] vb,
                       input logic he, input logic [W-1:0] res);
        row_t rw;
        rw.op              = o;
        {rw.clr, rw.av, rw.bv} = f;             // clear, a valid, b valid
        {rw.ra, rw.rb}     = rnd;
        rw.a               = va;
        rw.b               = vb;
        rw.he              = he;
        rw.res             = res;
        tbl.push_back(rw);
    endtask

    task automatic build_table();
        repeat (8) put(ADD, 3'b011, 2'b11, '0, '0, 1'b0, '0);   // back to back sums
        put(ADD, 3'b010, 2'b11, '0, '0, 1'b0, '0);              // a only, no result
        put(ADD, 3'b001, 2'b11, '0, '0, 1'b0, '0);              // b only
        put(ADD, 3'b011, 2'b00, 32'h7fff0000, 32'h00020000, 1'b1, 32'h80010000);  // wraps
        put(MUL, 3'b011, 2'b00, 32'h00028000, 32'h00018000, 1'b1, 32'h0003c000);  // 2.5*1.5
        put(MUL, 3'b011, 2'b00, 32'hfffe0000, 32'h00030000, 1'b1, 32'hfffa0000);  // -2*3
        put(MUL, 3'b011, 2'b00, 32'hfffe8000, 32'hffff8000, 1'b1, 32'h0000c000);  // -1.5*-0.5
        put(MUL, 3'b011, 2'b00, 32'h00644000, 32'h00040000, 1'b1, 32'h01910000);  // 100.25*4
        put(MUL, 3'b011, 2'b00, 32'h00000001, 32'h00008000, 1'b1, 32'h00000000);  // lsb lost
        put(MUL, 3'b011, 2'b00, 32'hffffffff, 32'h00008000, 1'b1, 32'hffffffff);  // floors
        put(MUL, 3'b011, 2'b00, 32'h012c0000, 32'h012c0000, 1'b1, 32'h5f900000);  // 300*300
        put(MUL, 3'b001, 2'b11, '0, '0, 1'b0, '0);
        repeat (4) put(MUL, 3'b011, 2'b11, '0, '0, 1'b0, '0);
        put(ACC, 3'b110, 2'b00, 32'h00010000, '0, 1'b1, 32'h00010000);   // clear with item
        put(ACC, 3'b010, 2'b00, 32'h00020000, '0, 1'b1, 32'h00030000);
        put(ACC, 3'b001, 2'b11, '0, '0, 1'b0, '0);                      // hole in the stream
        put(ACC, 3'b010, 2'b00, 32'h00008000, '0, 1'b1, 32'h00038000);
        put(ACC, 3'b110, 2'b00, 32'hffff0000, '0, 1'b1, 32'hffff0000);   // restart at -1
        put(ACC, 3'b010, 2'b00, 32'h00004000, '0, 1'b1, 32'hffff4000);
        put(ACC, 3'b100, 2'b00, '0, '0, 1'b0, '0);                      // clear alone
        repeat (5) put(ACC, 3'b010, 2'b11, '0, '0, 1'b0, '0);
        put(MACC, 3'b100, 2'b00, '0, '0, 1'b0, '0);     // clear with nothing in flight
        repeat (6) put(MACC, 3'b011, 2'b11, '0, '0, 1'b0, '0);
        put(MACC, 3'b010, 2'b11, '0, '0, 1'b0, '0);
        repeat (3) put(MACC, 3'b011, 2'b11, '0, '0, 1'b0, '0);
        repeat (4) put(NOP, 3'b011, 2'b11, '0, '0, 1'b0, '0);
        repeat (2) put(pe_pkg::pe_op_e'(3'd6), 3'b011, 2'b11, '0, '0, 1'b0, '0);  // unnamed code
    endtask

    task automatic check_outputs();
        logic         v1, v2;
        logic [W-1:0] d1, d2;
        if (exp_v1.size() < pe_pkg::PE_LAT) begin  // first items not through yet
            v1 = 1'b0;
            v2 = 1'b0;
            d1 = '0;
            d2 = '0;
        end else begin
            v1 = exp_v1.pop_front();
            v2 = exp_v2.pop_front();
            d1 = exp_d1.pop_front();
            d2 = exp_d2.pop_front();
        end
        n_chk++;
        if (out1_vld !== v1) begin
            n_err1++;
            $display("Error at %0t: o_out1_valid expected %b, got %b", $time, v1, out1_vld);
        end
        if (v1 && out1 !== d1) begin
            n_err1++;
            $display("Error at %0t: o_out1 expected %h, got %h", $time, d1, out1);
        end
        if (out2_vld !== v2) begin
            n_err2++;
            $display("Error at %0t: o_out2_valid expected %b, got %b", $time, v2, out2_vld);
        end
        if (v2 && out2 !== d2) begin
            n_err2++;
            $display("Error at %0t: o_out2 expected %h, got %h", $time, d2, out2);
        end
    endtask

    task automatic apply(input row_t rw);
        logic [W-1:0] va, vb, d1;
        logic         v1;
        @(negedge clk);
        check_outputs();                        // result of the item 16 cycles back
        va = rw.a;
        vb = rw.b;
        if (rw.ra) draw(va);
        if (rw.rb) draw(vb);
        op      = rw.op;
        acc_clr = rw.clr;
        a_vld   = rw.av;
        b_vld   = rw.bv;
        a       = va;
        b       = vb;
        v1      = 1'b0;
        d1      = '0;
        if (rw.clr) acc_model = '0;             // clears only sit where no product is in flight
        case (rw.op)
            ADD: begin
                v1 = rw.av & rw.bv;
                d1 = va + vb;
            end
            MUL: begin
                v1 = rw.av & rw.bv;
                d1 = q_mul(va, vb);
            end
            ACC: begin
                if (rw.av) acc_model = acc_model + va;
                v1 = rw.av;
                d1 = acc_model;
            end
            MACC: begin
                if (rw.av && rw.bv) acc_model = acc_model + q_mul(va, vb);
                v1 = rw.av & rw.bv;
                d1 = acc_model;
            end
            default: ;                          // nop, no o_out1
        endcase
        if (rw.he) d1 = rw.res;
        exp_v1.push_back(v1);
        exp_d1.push_back(d1);
        exp_v2.push_back(rw.av);                // a forwarded in every opcode
        exp_d2.push_back(va);
    endtask

    task automatic wait_reset(output logic ok);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            if (out1_vld !== 1'b0 || out2_vld !== 1'b0) begin
                n_err_misc++;
                $display("Error at %0t: o_out1_valid/o_out2_valid expected 0/0, got %b/%b",
                         $time, out1_vld, out2_vld);
            end
            n++;
        end while (arst_n !== 1'b1 && n < TIMEOUT);
        ok = (arst_n === 1'b1);
        if (!ok) begin
            n_err_misc++;
            $display("Timeout: reset was never released");
        end
    endtask

    initial begin
        row_t idle;
        logic ok;
        int   n;
        op         = NOP;
        a          = '0;
        b          = '0;
        a_vld      = 1'b0;
        b_vld      = 1'b0;
        acc_clr    = 1'b0;
        lfsr       = 32'hc467;
        acc_model  = '0;
        n_chk      = 0;
        n_err1     = 0;
        n_err2     = 0;
        n_err_misc = 0;
        idle       = '0;
        build_table();
        wait_reset(ok);
        if (ok) begin
            for (int r = 0; r < tbl.size(); r++) begin
                if (r > 0 && tbl[r].op != tbl[r-1].op) begin
                    idle.op = tbl[r-1].op;      // old opcode held until units are empty
                    repeat (GAP) apply(idle);
                end
                apply(tbl[r]);
            end
            idle.op = tbl[tbl.size()-1].op;
            n = 0;
            while (pending() && n < TIMEOUT) begin
                apply(idle);
                n++;
            end
            if (pending()) begin
                n_err_misc++;
                $display("Timeout: results still expected after %0d idle cycles", n);
            end
        end
        $display("checks %0d, errors o_out1 %0d, o_out2 %0d, other %0d",
                 n_chk, n_err1, n_err2, n_err_misc);
        if (n_err1 + n_err2 + n_err_misc == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clkgen.sv ====
module tb_clkgen #(
    parameter int PERIOD     = 4,               // time units per clock
    parameter int RST_CYCLES = 4                // rising edges seen in reset
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD/2) o_clk = ~o_clk;
    end

    initial begin
        o_arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;                        // release between rising edges
    end

endmodule

// ==== hdl/pe_type_c.sv ====
module pe_type_c (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  pe_pkg::pe_op_e            i_op,
    input  logic [pe_pkg::DWIDTH-1:0] i_a,
    input  logic                      i_a_valid,
    input  logic [pe_pkg::DWIDTH-1:0] i_b,
    input  logic                      i_b_valid,
    input  logic                      i_acc_clr,
    output logic [pe_pkg::DWIDTH-1:0] o_out1,         // unit result
    output logic                      o_out1_valid,
    output logic [pe_pkg::DWIDTH-1:0] o_out2,         // i_a forwarded to next element
    output logic                      o_out2_valid
);

    logic                      is_add, is_mul, is_acc, is_macc;  // opcode strobes
    logic                      both_vld;
    logic                      add_vld, mul_vld, acc_vld;
    logic                      mul_res_vld;                      // mul result for the mux
    logic [pe_pkg::DWIDTH-1:0] add_sum, mul_prod, acc_sum;
    logic                      acc_in_vld;
    logic [pe_pkg::DWIDTH-1:0] acc_in_data;
    logic                      mux_vld;
    logic [pe_pkg::DWIDTH-1:0] mux_data;
    logic                      res_vld_d;
    logic [pe_pkg::DWIDTH-1:0] res_d;
    logic [$clog2(pe_pkg::PE_LAT+1)-1:0] busy_cnt;             // cycles an item stays in flight

    always_comb begin
        is_add  = 1'b0;
        is_mul  = 1'b0;
        is_acc  = 1'b0;
        is_macc = 1'b0;
        case (i_op)
            pe_pkg::OP_ADD:  is_add  = 1'b1;
            pe_pkg::OP_ACC:  is_acc  = 1'b1;
            pe_pkg::OP_MUL:  is_mul  = 1'b1;
            pe_pkg::OP_MACC: is_macc = 1'b1;
            default: ;                          // OP_NOP and codes 5..7
        endcase
    end

    assign both_vld = i_a_valid & i_b_valid;

    fxp_add u_add (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_valid(both_vld & is_add), .i_a(i_a), .i_b(i_b),
        .o_valid(add_vld), .o_sum(add_sum)
    );

    fxp_mul u_mul (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_valid(both_vld & (is_mul | is_macc)), .i_a(i_a), .i_b(i_b),
        .o_valid(mul_vld), .o_prod(mul_prod)
    );

    // macc feeds the product stream, acc feeds operand a
    assign acc_in_vld  = is_macc ? mul_vld : (i_a_valid & is_acc);
    assign acc_in_data = is_macc ? mul_prod : i_a;
    assign mul_res_vld = mul_vld & ~is_macc;  // product already consumed by acc in macc

    fxp_acc u_acc (
        .clk(clk), .i_arst_n(i_arst_n), .i_clr(i_acc_clr),
        .i_valid(acc_in_vld), .i_data(acc_in_data),
        .o_valid(acc_vld), .o_sum(acc_sum)
    );

    always_comb begin
        case ({add_vld, mul_res_vld, acc_vld})
            3'b100: begin
                mux_vld  = 1'b1;
                mux_data = add_sum;
            end
            3'b010: begin
                mux_vld  = 1'b1;
                mux_data = mul_prod;
            end
            3'b001: begin                       // acc and macc
                mux_vld  = 1'b1;
                mux_data = acc_sum;
            end
            default: begin                      // none or a collision
                mux_vld  = 1'b0;
                mux_data = '0;
            end
        endcase
    end

    // single unit paths are 8 short of PE_LAT
    register_pipe #(.WIDTH(pe_pkg::DWIDTH+1), .DEPTH(pe_pkg::PE_LAT-pe_pkg::ADD_LAT)) u_res_pipe (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_d({mux_vld, mux_data}), .o_q({res_vld_d, res_d})
    );

    register_pipe #(.WIDTH(pe_pkg::DWIDTH+1), .DEPTH(pe_pkg::PE_LAT)) u_a_pipe (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_d({i_a_valid, i_a}), .o_q({o_out2_valid, o_out2})
    );

    // mul plus acc already spans PE_LAT
    assign o_out1       = is_macc ? mux_data : res_d;
    assign o_out1_valid = is_macc ? mux_vld : res_vld_d;

    // reload on every unit input, counts down to idle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_cnt <= '0;
        end else if ((both_vld & (is_add | is_mul | is_macc)) | acc_in_vld) begin
            busy_cnt <= $bits(busy_cnt)'(pe_pkg::PE_LAT);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    a_one_unit_vld : assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0({add_vld, mul_res_vld, acc_vld}));

    a_op_stable : assert property (@(posedge clk) disable iff (!i_arst_n)
        (busy_cnt != '0) |-> $stable(i_op));

endmodule

// ==== hdl/fxp_acc.sv ====
module fxp_acc (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_clr,     // restart the running sum
    input  logic                      i_valid,
    input  logic [pe_pkg::DWIDTH-1:0] i_data,
    output logic                      o_valid,
    output logic [pe_pkg::DWIDTH-1:0] o_sum
);

    logic [pe_pkg::DWIDTH-1:0] sum_q;                      // running sum, one per cycle
    logic [pe_pkg::DWIDTH-1:0] base;                       // sum the new item adds to
    logic [pe_pkg::DWIDTH-1:0] sum_d;
    logic                      upd_q;                      // sum_q changed by an item
    logic [pe_pkg::DWIDTH-1:0] dly_q [pe_pkg::ACC_LAT-1];  // output alignment
    logic [pe_pkg::ACC_LAT-2:0] vld_q;

    // a clear and an item in the same cycle start a new sum with that item
    always_comb begin
        base  = i_clr ? '0 : sum_q;
        sum_d = i_valid ? base + i_data : base;  // wraps mod 2^32
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sum_q <= '0;
            upd_q <= 1'b0;
        end else begin
            sum_q <= sum_d;                     // holds when idle and no clear
            upd_q <= i_valid;                   // clear alone gives no output
        end
    end

    // ACC_LAT-1 stages behind the sum register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_q <= '0;
            for (int i = 0; i < pe_pkg::ACC_LAT-1; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            vld_q    <= {vld_q[pe_pkg::ACC_LAT-3:0], upd_q};
            dly_q[0] <= sum_q;                  // snapshot after each update
            for (int i = 1; i < pe_pkg::ACC_LAT-1; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign o_valid = vld_q[pe_pkg::ACC_LAT-2];
    assign o_sum   = dly_q[pe_pkg::ACC_LAT-2];

    // whole pipe starts empty, nothing leaks out right after reset
    a_no_vld_after_rst : assert property (@(posedge clk) $rose(i_arst_n) |=> !o_valid);

endmodule

// ==== hdl/fxp_mul.sv ====
module fxp_mul (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  logic [pe_pkg::DWIDTH-1:0] i_a,       // signed Q16.16
    input  logic [pe_pkg::DWIDTH-1:0] i_b,       // signed Q16.16
    output logic                      o_valid,
    output logic [pe_pkg::DWIDTH-1:0] o_prod     // signed Q16.16, truncated
);

    logic signed [2*pe_pkg::DWIDTH-1:0] prod_q;            // full Q32.32 product
    logic [pe_pkg::DWIDTH-1:0] slc_q [pe_pkg::MUL_LAT-1];  // slice stage plus delay
    logic [pe_pkg::MUL_LAT-1:0] vld_q;

    // stage 1 multiplies, stage 2 slices, the rest delay
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            prod_q <= '0;
            vld_q  <= '0;
            for (int i = 0; i < pe_pkg::MUL_LAT-1; i++) begin
                slc_q[i] <= '0;
            end
        end else begin
            vld_q  <= {vld_q[pe_pkg::MUL_LAT-2:0], i_valid};
            prod_q <= $signed(i_a) * $signed(i_b);   // 64 bit signed product
            // drop the low FRAC bits, keep 47..16
            slc_q[0] <= prod_q[pe_pkg::DWIDTH+pe_pkg::FRAC-1:pe_pkg::FRAC];
            for (int i = 1; i < pe_pkg::MUL_LAT-1; i++) begin
                slc_q[i] <= slc_q[i-1];
            end
        end
    end

    assign o_valid = vld_q[pe_pkg::MUL_LAT-1];
    assign o_prod  = slc_q[pe_pkg::MUL_LAT-2];

endmodule

// ==== hdl/fxp_add.sv ====
module fxp_add (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_valid,   // both operands present
    input  logic [pe_pkg::DWIDTH-1:0] i_a,
    input  logic [pe_pkg::DWIDTH-1:0] i_b,
    output logic                      o_valid,
    output logic [pe_pkg::DWIDTH-1:0] o_sum
);

    logic [pe_pkg::DWIDTH-1:0] sum_q [pe_pkg::ADD_LAT];  // stage 0 holds the fresh sum
    logic [pe_pkg::ADD_LAT-1:0] vld_q;                   // valid shift, lsb first

    // stage 0 adds, later stages only carry the result
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_q <= '0;
            for (int i = 0; i < pe_pkg::ADD_LAT; i++) begin
                sum_q[i] <= '0;
            end
        end else begin
            vld_q    <= {vld_q[pe_pkg::ADD_LAT-2:0], i_valid};
            sum_q[0] <= i_a + i_b;              // wraps mod 2^32, no saturation
            for (int i = 1; i < pe_pkg::ADD_LAT; i++) begin
                sum_q[i] <= sum_q[i-1];         // latency filler
            end
        end
    end

    assign o_valid = vld_q[pe_pkg::ADD_LAT-1];
    assign o_sum   = sum_q[pe_pkg::ADD_LAT-1];

endmodule

// ==== hdl/register_pipe.sv ====
module register_pipe #(
    parameter int WIDTH = 1,                    // bits per stage
    parameter int DEPTH = 1                     // number of stages, at least 1
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic [WIDTH-1:0] i_d,
    output logic [WIDTH-1:0] o_q                // i_d delayed by DEPTH cycles
);

    logic [WIDTH-1:0] stage_q [DEPTH];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;               // valid bits included, pipe empty
            end
        end else begin
            stage_q[0] <= i_d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_q = stage_q[DEPTH-1];

endmodule

// ==== hdl/pe_pkg.sv ====
package pe_pkg;

    // datapath format, signed Q16.16
    localparam int DWIDTH = 32;                 // operand and result width
    localparam int FRAC   = 16;                 // fraction bits

    // unit latencies in clock cycles
    localparam int ADD_LAT = 8;                 // adder, input valid to result valid
    localparam int MUL_LAT = 8;                 // multiplier
    localparam int ACC_LAT = 8;                 // accumulator, sample to running sum out

    // element latency, operands to o_out1 and i_a to o_out2
    localparam int PE_LAT = 16;

    // opcode of the processing element
    // codes 5 to 7 are not named and decode as nop
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,                         // a + b
        OP_ACC  = 3'd1,                         // running sum of a
        OP_MUL  = 3'd2,                         // a * b
        OP_MACC = 3'd3,                         // running sum of a * b
        OP_NOP  = 3'd4                          // pass-through only
    } pe_op_e;

endpackage
